/* Makefile */
TOP := cu_control_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cu_control.f verilog/*.sv verif/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f cu_control.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation completed successfully$$"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f cu_control.f

clean:
	rm -rf obj_dir

/* cu_control.f */
verilog/cu_pkg.sv
verilog/cu_credit_counter.sv
verilog/cu_job_fsm.sv
verilog/cu_read_engine.sv
verilog/cu_vertex_buffer.sv
verilog/cu_write_engine.sv
verilog/cu_control.sv
verif/cu_control_asserts.sv
verif/cu_control_tb.sv

/* verif/cu_control_asserts.sv */
module cu_control_asserts import cu_pkg::*; (
	input logic          clock,
	input logic          rstn,
	input command_line_t read_cmd,
	input command_line_t write_cmd,
	input logic          vertices_done
);

	// one sticky flag per property
	logic share_bad = 1'b0;
	logic early_bad = 1'b0;
	logic late_bad  = 1'b0;
	logic tripped;

	assign tripped = share_bad | early_bad | late_bad;

	// one command credit is taken per cycle
	cmd_exclusive: assert property (@(posedge clock) disable iff (!rstn)
		!(read_cmd.valid && write_cmd.valid))
		else begin
			$error("read and write command issued in the same cycle");
			share_bad = 1'b1;
		end

	write_after_drain: assert property (@(posedge clock) disable iff (!rstn)
		write_cmd.valid |-> vertices_done)
		else begin
			$error("completion write while vertices are still pending");
			early_bad = 1'b1;
		end

	read_before_drain: assert property (@(posedge clock) disable iff (!rstn)
		read_cmd.valid |-> !vertices_done) // buffer still waits for this line
		else begin
			$error("read command after the vertex buffer finished");
			late_bad = 1'b1;
		end

endmodule

bind cu_control cu_control_asserts u_asserts (
	.clock(clock),
	.rstn(rstn),
	.read_cmd(read_cmd),
	.write_cmd(write_cmd),
	.vertices_done(vertices_done)
);

/* verif/cu_control_tb.sv */
module cu_control_tb import cu_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int NUM_JOBS   = 8;
	localparam int MAX_VERTS  = 40;
	localparam int MAX_LINES  = MAX_VERTS / VERTS_PER_LINE;
	localparam int IDX_W      = $clog2(MAX_LINES);
	localparam int MAX_DELAY  = 40;
	localparam int WATCHDOG_CYCLES = NUM_JOBS * (MAX_VERTS + 8) * 2 * MAX_DELAY + 100;

	logic           clock;
	logic           rstn;
	logic           enabled;
	wed_t           wed_in;
	response_line_t read_response_in;
	data_line_t     read_data_in;
	response_line_t write_response_in;
	logic           cmd_credit_return;
	logic           vertex_credit_return;
	command_line_t  command_out;
	data_line_t     write_data_out;
	vertex_t        vertex_out;
	logic           done;

	integer seed = 95;
	int cycle, errors, checks, tests_run, tests_failed, test_start_errors;

	// host memory image and job progress
	logic [LINE_W-1:0] image [MAX_LINES];
	logic [ADDR_W-1:0] job_base;
	int  job_count, reads_seen, verts_seen, writes_seen, dones_seen;
	int  cmd_outstanding, verts_unreturned, write_resp_time;
	bit  write_resp_sent, slow_host;
	int  read_idx_q[$];
	int  read_time_q[$];
	int  cmd_credit_q[$];
	int  vertex_credit_q[$];

	cu_control u_dut (
		.clock(clock), .rstn(rstn), .enabled(enabled), .wed_in(wed_in),
		.read_response_in(read_response_in), .read_data_in(read_data_in),
		.write_response_in(write_response_in), .cmd_credit_return(cmd_credit_return),
		.vertex_credit_return(vertex_credit_return), .command_out(command_out),
		.write_data_out(write_data_out), .vertex_out(vertex_out), .done(done));

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: a job did not complete within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

////////////////////////////////////////
// helpers
////////////////////////////////////////

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// mostly short, now and then a long stall
	function automatic int pick_delay();
		if (rand_below(slow_host ? 3 : 10) == 0)
			return 8 + rand_below(MAX_DELAY - 8);
		return rand_below(4);
	endfunction

	function automatic int in_order(int wanted, int last);
		return (wanted > last) ? wanted : last + 1;
	endfunction

	function automatic int lines_for(int n);
		return (n + VERTS_PER_LINE - 1) / VERTS_PER_LINE;
	endfunction

	// record k of the image, rec 0 in the low 32 bits of a line
	function automatic logic [31:0] image_record(int k);
		logic [LINE_W-1:0] line;
		line = image[IDX_W'(k / VERTS_PER_LINE)];
		return 32'(line >> (32 * (k % VERTS_PER_LINE)));
	endfunction

	task automatic expect_that(input bit ok, input string msg);
		checks++;
		assert (ok) else begin
			$display("CHECK FAILED at %0t: %s", $time, msg);
			errors++;
		end
	endtask

////////////////////////////////////////
// host and consumer models
////////////////////////////////////////

	task automatic observe_outputs();
		int t;
		int idx;
		logic [31:0] rec;
		if (command_out.valid) begin
			cmd_outstanding++;
			expect_that(cmd_outstanding <= CMD_CREDITS,
				$sformatf("%0d commands outstanding", cmd_outstanding));
			t = cycle + 1 + pick_delay();
			if (cmd_credit_q.size() > 0)
				t = in_order(t, cmd_credit_q[$]);
			cmd_credit_q.push_back(t);
			if (command_out.command == READ_CL) begin
				expect_that(reads_seen < lines_for(job_count), "read past the last line");
				expect_that(command_out.address == job_base + ADDR_W'(16 * reads_seen),
					$sformatf("read address %h for line %0d", command_out.address, reads_seen));
				expect_that(command_out.cmd.line_idx == 16'(reads_seen) &&
					command_out.cmd.cu_id == CU_ID &&
					command_out.cmd.cmd_type == CMD_READ, "read tag wrong");
				idx = int'((command_out.address - job_base) >> 4);
				if (idx < 0 || idx >= MAX_LINES)
					idx = 0;
				t = cycle + 1 + pick_delay();
				if (read_time_q.size() > 0)
					t = in_order(t, read_time_q[$]);
				read_time_q.push_back(t);
				read_idx_q.push_back(idx);
				reads_seen++;
			end else if (command_out.command == WRITE_MS) begin
				expect_that(verts_seen == job_count, "completion write before the last vertex");
				expect_that(command_out.address == job_base + ADDR_W'(DONE_OFFSET) &&
					command_out.size == 12'd1,
					$sformatf("write address %h size %0d", command_out.address, command_out.size));
				expect_that(command_out.cmd.cu_id == CU_ID &&
					command_out.cmd.cmd_type == CMD_WRITE, "write tag wrong");
				expect_that(write_data_out.valid &&
					write_data_out.data.raw == LINE_W'(job_count) &&
					write_data_out.cmd.cu_id == CU_ID &&
					write_data_out.cmd.cmd_type == CMD_WRITE,
					$sformatf("completion data %h", write_data_out.data.raw));
				write_resp_time = cycle + 1 + pick_delay();
				writes_seen++;
			end else
				expect_that(1'b0, "command of unknown kind");
		end else
			expect_that(!write_data_out.valid, "write data without a command");
		if (vertex_out.valid) begin
			verts_unreturned++;
			expect_that(verts_unreturned <= VERTEX_CREDITS,
				$sformatf("%0d vertices unreturned", verts_unreturned));
			t = cycle + 1 + pick_delay();
			if (vertex_credit_q.size() > 0)
				t = in_order(t, vertex_credit_q[$]);
			vertex_credit_q.push_back(t);
			expect_that(verts_seen < job_count, "vertex past the vertex count");
			if (verts_seen < job_count) begin
				rec = image_record(verts_seen);
				expect_that(vertex_out.id == 16'(verts_seen) &&
					vertex_out.out_degree == rec[31:16] && vertex_out.edge_index == rec[15:0],
					$sformatf("vertex %0d got id %0d record %h_%h", verts_seen, vertex_out.id,
					vertex_out.out_degree, vertex_out.edge_index));
			end
			verts_seen++;
		end
		if (done) begin
			dones_seen++;
			expect_that(write_resp_sent, "done before the write response");
		end
	endtask

	task automatic drive_inputs(input bit send_wed);
		int idx;
		wed_in               = '0;
		read_response_in     = '0;
		read_data_in         = '0;
		write_response_in    = '0;
		cmd_credit_return    = 1'b0;
		vertex_credit_return = 1'b0;
		if (send_wed) begin
			wed_in.valid        = 1'b1;
			wed_in.address      = job_base;
			wed_in.vertex_count = 16'(job_count);
		end
		if (read_time_q.size() > 0 && read_time_q[0] <= cycle) begin
			void'(read_time_q.pop_front());
			idx = read_idx_q.pop_front();
			read_response_in.valid        = 1'b1;
			read_response_in.cmd.cu_id    = CU_ID;
			read_response_in.cmd.cmd_type = CMD_READ;
			read_response_in.cmd.line_idx = 16'(idx);
			read_data_in.valid            = 1'b1; // data rides with its response
			read_data_in.cmd              = read_response_in.cmd;
			read_data_in.data.raw         = image[IDX_W'(idx)];
		end
		if (cmd_credit_q.size() > 0 && cmd_credit_q[0] <= cycle) begin
			void'(cmd_credit_q.pop_front());
			cmd_credit_return = 1'b1;
			cmd_outstanding--;
		end
		if (vertex_credit_q.size() > 0 && vertex_credit_q[0] <= cycle) begin
			void'(vertex_credit_q.pop_front());
			vertex_credit_return = 1'b1;
			verts_unreturned--;
		end
		if (write_resp_time >= 0 && write_resp_time <= cycle) begin
			write_response_in.valid        = 1'b1;
			write_response_in.cmd.cu_id    = CU_ID;
			write_response_in.cmd.cmd_type = CMD_WRITE;
			write_resp_sent = 1'b1;
			write_resp_time = -1;
		end
	endtask

	task automatic step(input bit send_wed);
		@(negedge clock);
		cycle++;
		observe_outputs();
		drive_inputs(send_wed);
	endtask

////////////////////////////////////////
// tests
////////////////////////////////////////

	task automatic end_test(input string name);
		tests_run++;
		if (errors != test_start_errors)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name,
			(errors == test_start_errors) ? "passed" : "failed");
		test_start_errors = errors;
	endtask

	task automatic run_job(input int count, input bit slow);
		job_base  = {$random(seed), $random(seed)} & ~64'hff;
		job_count = count;
		slow_host = slow;
		for (int i = 0; i < MAX_LINES; i++)
			image[IDX_W'(i)] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		reads_seen      = 0;
		verts_seen      = 0;
		writes_seen     = 0;
		dones_seen      = 0;
		write_resp_sent = 1'b0;
		step(1'b1); // one cycle descriptor
		while (dones_seen == 0)
			step(1'b0);
		repeat (6) step(1'b0); // catch a late second done or write
		expect_that(reads_seen == lines_for(count), $sformatf("%0d reads", reads_seen));
		expect_that(verts_seen == count, $sformatf("%0d vertices", verts_seen));
		expect_that(writes_seen == 1, $sformatf("%0d completion writes", writes_seen));
		expect_that(dones_seen == 1, $sformatf("%0d done pulses", dones_seen));
	endtask

	initial begin
		int count;
		cycle = 0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		test_start_errors = 0;
		job_base = '0;
		job_count = 0;
		cmd_outstanding = 0;
		verts_unreturned = 0;
		write_resp_time = -1;
		write_resp_sent = 1'b0;
		slow_host = 1'b0;
		rstn    = 1'b0;
		enabled = 1'b0;
		drive_inputs(1'b0);
		repeat (4) @(posedge clock);
		@(negedge clock);
		rstn    = 1'b1;
		enabled = 1'b1;
		repeat (20) begin
			step(1'b0);
			expect_that(!command_out.valid && !write_data_out.valid && !vertex_out.valid &&
				!done, "output active before any descriptor");
		end
		end_test("idle after reset");
		run_job(13, 1'b0);
		end_test("job of 13 vertices");
		run_job(MAX_VERTS, 1'b1);
		end_test("full job under long back-pressure");
		for (int j = 0; j < NUM_JOBS - 2; j++) begin
			count = 1 + rand_below(MAX_VERTS);
			run_job(count, j == 2);
			end_test($sformatf("random job of %0d vertices", count));
		end
		if (u_dut.u_asserts.tripped) begin
			$display("bound concurrent assertions reported a failure");
			errors++;
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* verilog/cu_control.sv */
module cu_control import cu_pkg::*; (
	input  logic           clock,
	input  logic           rstn,
	input  logic           enabled,
	input  wed_t           wed_in,
	input  response_line_t read_response_in,
	input  data_line_t     read_data_in,
	input  response_line_t write_response_in,
	input  logic           cmd_credit_return,
	input  logic           vertex_credit_return,
	output command_line_t  command_out,
	output data_line_t     write_data_out,
	output vertex_t        vertex_out,
	output logic           done
);

	// registered inputs
	logic           enabled_q;
	wed_t           wed_q;
	response_line_t read_response_q;
	data_line_t     read_data_q;
	response_line_t write_response_q;
	logic           cmd_credit_q;
	logic           vertex_credit_q;

	// internal
	command_line_t read_cmd, write_cmd;
	data_line_t    write_data, buf_data;
	vertex_t       vertex;
	logic          fetch, write_req, job_done, reads_done, vertices_done;
	logic          cmd_ok, slot_ok, vertex_ok, slot_free, write_resp;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			enabled_q        <= 1'b0;
			wed_q            <= '0;
			read_response_q  <= '0;
			read_data_q      <= '0;
			write_response_q <= '0;
			cmd_credit_q     <= 1'b0;
			vertex_credit_q  <= 1'b0;
			command_out      <= '0;
			write_data_out   <= '0;
			vertex_out       <= '0;
			done             <= 1'b0;
		end else begin
			enabled_q        <= enabled;
			wed_q            <= wed_in;
			read_response_q  <= read_response_in;
			read_data_q      <= read_data_in;
			write_response_q <= write_response_in;
			cmd_credit_q     <= cmd_credit_return;
			vertex_credit_q  <= vertex_credit_return;
			command_out      <= read_cmd.valid ? read_cmd : write_cmd; // never both
			write_data_out   <= write_data;
			vertex_out       <= vertex;
			done             <= job_done;
		end
	end

	always_comb begin
		buf_data       = read_data_q;
		buf_data.valid = read_data_q.valid && read_response_q.valid;
	end

	assign write_resp = write_response_q.valid && write_response_q.cmd.cmd_type == CMD_WRITE;

////////////////////////////////////////
// job sequencing and credits
////////////////////////////////////////

	cu_job_fsm job_fsm (
		.clock(clock), .rstn(rstn), .enabled(enabled_q), .wed(wed_q),
		.reads_done(reads_done), .vertices_done(vertices_done),
		.write_response(write_resp), .fetch(fetch), .write_req(write_req), .done(job_done));

	cu_credit_counter #(.CREDITS(CMD_CREDITS)) cmd_credits (
		.clock(clock), .rstn(rstn), .consume(read_cmd.valid | write_cmd.valid),
		.give_back(cmd_credit_q), .available(cmd_ok));

	cu_credit_counter #(.CREDITS(VERTEX_LINES)) slot_credits (
		.clock(clock), .rstn(rstn), .consume(read_cmd.valid),
		.give_back(slot_free), .available(slot_ok));

	cu_credit_counter #(.CREDITS(VERTEX_CREDITS)) vertex_credits (
		.clock(clock), .rstn(rstn), .consume(vertex.valid),
		.give_back(vertex_credit_q), .available(vertex_ok));

////////////////////////////////////////
// data engines
////////////////////////////////////////

	cu_read_engine read_engine (
		.clock(clock), .rstn(rstn), .fetch(fetch), .wed(wed_q), .cmd_ok(cmd_ok),
		.slot_ok(slot_ok), .read_command(read_cmd), .reads_done(reads_done));

	cu_vertex_buffer vertex_buffer (
		.clock(clock), .rstn(rstn), .start(wed_q.valid & enabled_q & ~fetch),
		.vertex_count(wed_q.vertex_count), .read_data(buf_data), .vertex_ok(vertex_ok),
		.vertex(vertex), .slot_free(slot_free), .vertices_done(vertices_done));

	cu_write_engine write_engine (
		.clock(clock), .rstn(rstn), .write_req(write_req), .wed(wed_q), .cmd_ok(cmd_ok),
		.write_command(write_cmd), .write_data(write_data));

endmodule

/* verilog/cu_credit_counter.sv */
module cu_credit_counter #(
	parameter int CREDITS = 4
) (
	input  logic clock,
	input  logic rstn,
	input  logic consume,
	input  logic give_back,
	output logic available
);

	localparam int CNT_W = $clog2(CREDITS + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			count <= CNT_W'(CREDITS);
		end else if (consume && !give_back) begin
			count <= count - 1'b1;
		end else if (give_back && !consume && count != CNT_W'(CREDITS)) begin
			count <= count + 1'b1; // saturate at the initial count
		end
	end

	assign available = (count != '0);

endmodule

/* verilog/cu_job_fsm.sv */
module cu_job_fsm import cu_pkg::*; (
	input  logic clock,
	input  logic rstn,
	input  logic enabled,
	input  wed_t wed,
	input  logic reads_done,
	input  logic vertices_done,
	input  logic write_response,
	output logic fetch,
	output logic write_req,
	output logic done
);

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DRAIN,
		WRITE,
		WAIT_WRITE,
		FINISH
	} state_t;

	state_t state;
	logic [15:0] job_count; // vertex count of the running job

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			state     <= IDLE;
			job_count <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (enabled && wed.valid) begin
						state     <= FETCH;
						job_count <= wed.vertex_count;
					end
				end
				FETCH: begin
					if (job_count == '0)
						state <= WRITE; // empty job, only the completion word
					else if (reads_done)
						state <= DRAIN;
				end
				DRAIN: begin
					if (vertices_done)
						state <= WRITE;
				end
				WRITE:      state <= WAIT_WRITE;
				WAIT_WRITE: if (write_response) state <= FINISH;
				FINISH:     state <= IDLE;
				default:    state <= IDLE;
			endcase
		end
	end

	assign fetch     = (state == FETCH);
	assign write_req = (state == WRITE); // one cycle request
	assign done      = (state == FINISH);

endmodule

/* verilog/cu_pkg.sv */
package cu_pkg;

////////////////////////////////////////
// sizes and credits
////////////////////////////////////////

	localparam int ADDR_W         = 64;
	localparam int LINE_W         = 128;
	localparam int VERTS_PER_LINE = 4;
	localparam int CMD_CREDITS    = 4;   // host command buffer depth
	localparam int VERTEX_LINES   = 4;   // line slots in vertex buffer
	localparam int VERTEX_CREDITS = 8;   // consumer input depth
	localparam int DONE_OFFSET    = 108; // completion word, from wed address
	localparam logic [7:0] CU_ID  = 8'h02;

////////////////////////////////////////
// command and response lines
////////////////////////////////////////

	typedef enum logic [1:0] {
		INVALID,
		READ_CL,
		WRITE_MS
	} command_t;

	typedef enum logic [1:0] {
		CMD_INVALID,
		CMD_READ,
		CMD_WRITE
	} cmd_type_t;

	typedef struct packed {
		logic [7:0]  cu_id;
		cmd_type_t   cmd_type;
		logic [15:0] line_idx; // line index within the vertex array
	} cmd_tag_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] address;
		logic [15:0]       vertex_count;
	} wed_t;

	typedef struct packed {
		logic              valid;
		command_t          command;
		logic [ADDR_W-1:0] address;
		logic [11:0]       size;
		cmd_tag_t          cmd;
	} command_line_t;

	// reads only, data travels on data_line_t
	typedef struct packed {
		logic     valid;
		cmd_tag_t cmd;
	} response_line_t;

////////////////////////////////////////
// vertex data
////////////////////////////////////////

	typedef struct packed {
		logic [15:0] out_degree;
		logic [15:0] edge_index;
	} vertex_rec_t;

	// rec[0] sits in the low 32 bits
	typedef union packed {
		logic [LINE_W-1:0]                     raw;
		vertex_rec_t [VERTS_PER_LINE-1:0] rec;
	} vertex_line_u;

	typedef struct packed {
		logic        valid;
		logic [15:0] id;
		logic [15:0] out_degree;
		logic [15:0] edge_index;
	} vertex_t;

	typedef struct packed {
		logic         valid;
		cmd_tag_t     cmd;
		vertex_line_u data;
	} data_line_t;

endpackage

/* verilog/cu_read_engine.sv */
module cu_read_engine import cu_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          fetch,
	input  wed_t          wed,
	input  logic          cmd_ok,
	input  logic          slot_ok,
	output command_line_t read_command,
	output logic          reads_done
);

	localparam int LINE_BYTES = LINE_W / 8;
	localparam int VPL_SHIFT  = $clog2(VERTS_PER_LINE);

	logic [ADDR_W-1:0] base;
	logic [15:0]       line_idx;
	logic [15:0]       lines_left;
	logic              issue;

	assign issue      = fetch && cmd_ok && slot_ok && (lines_left != '0);
	assign reads_done = fetch && (lines_left == '0);

	// descriptor is taken while not fetching
	always_ff @(posedge clock) begin
		if (!fetch && wed.valid)
			base <= wed.address;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			line_idx   <= '0;
			lines_left <= '0;
		end else if (!fetch && wed.valid) begin
			line_idx   <= '0;
			lines_left <= 16'((17'(wed.vertex_count) + 17'(VERTS_PER_LINE - 1)) >> VPL_SHIFT);
		end else if (issue) begin
			line_idx   <= line_idx + 1'b1;
			lines_left <= lines_left - 1'b1;
		end
	end

	always_comb begin
		read_command = '0;
		if (issue) begin
			read_command.valid        = 1'b1;
			read_command.command      = READ_CL;
			read_command.address      = base + (ADDR_W'(line_idx) * LINE_BYTES);
			read_command.size         = 12'(LINE_BYTES);
			read_command.cmd.cu_id    = CU_ID;
			read_command.cmd.cmd_type = CMD_READ;
			read_command.cmd.line_idx = line_idx;
		end
	end

endmodule

/* verilog/cu_vertex_buffer.sv */
module cu_vertex_buffer import cu_pkg::*; (
	input  logic        clock,
	input  logic        rstn,
	input  logic        start,
	input  logic [15:0] vertex_count,
	input  data_line_t  read_data,
	input  logic        vertex_ok,
	output vertex_t     vertex,
	output logic        slot_free,
	output logic        vertices_done
);

	localparam int SLOT_W = $clog2(VERTEX_LINES);
	localparam int REC_W  = $clog2(VERTS_PER_LINE);

	vertex_line_u             mem [VERTEX_LINES];
	logic [VERTEX_LINES-1:0]  slot_valid;
	logic [SLOT_W-1:0]        rd_ptr;
	logic [SLOT_W-1:0]        wr_slot;
	logic [REC_W-1:0]         rec_idx;
	logic [15:0]              next_id;
	logic [15:0]              last_id;
	logic                     active;
	logic                     emit;
	logic                     last_rec;
	vertex_rec_t              rec;

	assign wr_slot = read_data.cmd.line_idx[SLOT_W-1:0]; // lines come back in order

	always_ff @(posedge clock) begin
		if (read_data.valid)
			mem[wr_slot] <= read_data.data;
	end

	assign emit          = active && slot_valid[rd_ptr] && vertex_ok;
	assign last_rec      = (next_id == last_id);
	assign slot_free     = emit && (rec_idx == REC_W'(VERTS_PER_LINE - 1) || last_rec);
	assign vertices_done = !active;
	assign rec           = mem[rd_ptr].rec[rec_idx];

	always_comb begin
		vertex = '0;
		if (emit) begin
			vertex.valid      = 1'b1;
			vertex.id         = next_id;
			vertex.out_degree = rec.out_degree;
			vertex.edge_index = rec.edge_index;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn) begin
			active     <= 1'b0;
			slot_valid <= '0;
			rd_ptr     <= '0;
			rec_idx    <= '0;
			next_id    <= '0;
			last_id    <= '0;
		end else if (start) begin
			active     <= (vertex_count != '0);
			slot_valid <= '0;
			rd_ptr     <= '0;
			rec_idx    <= '0;
			next_id    <= '0;
			last_id    <= vertex_count - 16'd1;
		end else begin
			if (emit) begin
				next_id <= next_id + 1'b1;
				rec_idx <= slot_free ? '0 : rec_idx + 1'b1;
				if (slot_free)
					rd_ptr <= rd_ptr + 1'b1;
				if (last_rec)
					active <= 1'b0; // tail records of the last line are dropped
			end
			if (slot_free)
				slot_valid[rd_ptr] <= 1'b0;
			if (read_data.valid)
				slot_valid[wr_slot] <= 1'b1;
		end
	end

endmodule

/* verilog/cu_write_engine.sv */
module cu_write_engine import cu_pkg::*; (
	input  logic          clock,
	input  logic          rstn,
	input  logic          write_req,
	input  wed_t          wed,
	input  logic          cmd_ok,
	output command_line_t write_command,
	output data_line_t    write_data
);

	logic [ADDR_W-1:0] done_addr;
	logic [15:0]       count;
	logic              pending;
	logic              issue;

	assign issue = pending && cmd_ok;

	always_ff @(posedge clock) begin
		if (wed.valid && !pending) begin
			done_addr <= wed.address + ADDR_W'(DONE_OFFSET);
			count     <= wed.vertex_count;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (~rstn)
			pending <= 1'b0;
		else if (write_req)
			pending <= 1'b1;
		else if (issue)
			pending <= 1'b0;
	end

	always_comb begin
		write_command = '0;
		write_data    = '0;
		if (issue) begin
			write_command.valid        = 1'b1;
			write_command.command      = WRITE_MS;
			write_command.address      = done_addr;
			write_command.size         = 12'h001;
			write_command.cmd.cu_id    = CU_ID;
			write_command.cmd.cmd_type = CMD_WRITE;
			write_data.valid           = 1'b1;
			write_data.cmd             = write_command.cmd;
			write_data.data.raw        = LINE_W'(count);
		end
	end

endmodule
